//--- verilog.f
hdl/calc_pkg.sv
hdl/calc_entry.sv
hdl/add_sub_unit.sv
hdl/shift_add_multiplier.sv
hdl/result_display.sv
hdl/calculator_top.sv
tb/calculator_sva.sv
tb/calculator_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and set the exit status from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module calculator_tb -f verilog.f -o calculator_sim &&
out=$(./obj_dir/calculator_sim 2>&1 || true) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx 'Testbench passed' &&
echo "Simulation PASS" && exit 0 ||
{ echo "Simulation FAIL"; exit 1; }

//--- tb/calculator_tb.sv
`timescale 1ns/10ps

module calculator_tb;
    import calc_pkg::*;

    localparam int WAIT_LIMIT = 100;     // Cycles before a wait gives up

    logic     clk;
    logic     nRST;
    digit_t   keypad_input;
    logic     read_input;
    op_code_t operator_input;
    logic     equal_input;
    operand_t display_output;
    logic     complete;
    int       error_count;
    int       check_count;
    int       test_count;

    calculator_top i_calculator_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;          // 20 ns period
    end

    task automatic apply_reset();
        @(posedge clk);
        nRST <= 1'b0;
        repeat (3) @(posedge clk);
        nRST <= 1'b1;
        @(posedge clk);
    endtask

    task automatic press_digit(input digit_t code);
        @(posedge clk);
        keypad_input <= code;
        read_input   <= 1'b1;
        @(posedge clk);
        read_input   <= 1'b0;
    endtask

    task automatic enter_number(input int value);
        int digits[$];
        int rest;
        rest = value;
        do begin
            digits.push_front(rest % 10);  // Most significant digit ends up first
            rest = rest / 10;
        end while (rest > 0);
        foreach (digits[i]) begin
            press_digit(digit_t'(digits[i]));
        end
    endtask

    task automatic press_operator(input op_code_t code);
        @(posedge clk);
        operator_input <= code;
        @(posedge clk);
        operator_input <= '0;
    endtask

    task automatic press_equal();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;
    endtask

    // complete drops for at least one cycle after the start strobe
    // Cycles count from the edge that drove equal when called right after press_equal
    task automatic wait_complete(output int cycles);
        cycles = 1;
        @(negedge clk);
        while (complete && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (complete) begin
            error_count++;
            $display("Timeout: complete never dropped after equal");
            return;
        end
        while (!complete && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!complete) begin
            error_count++;
            $display("Timeout: complete did not rise within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic check_value(input string name, input operand_t actual, input operand_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic calculate(input int a, input op_code_t op, input int b, input int expected);
        int cycles;
        int expected_cycles;
        expected_cycles = (op == OP_MUL) ? OPERAND_W + 2 : 3;   // Equal to complete
        enter_number(a);
        press_operator(op);
        enter_number(b);
        press_equal();
        wait_complete(cycles);
        check_value("display_output", display_output, operand_t'(expected));
        check_value("latency", operand_t'(cycles), operand_t'(expected_cycles));
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_reset();
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        check_value("display_output", display_output, '0);
        check_value("complete", operand_t'(complete), '0);
        report_test("reset", errors_before);
    endtask

    task automatic test_add();
        int errors_before;
        errors_before = error_count;
        calculate(123, OP_ADD, 4567, (123 + 4567) % 65536);
        calculate(65535, OP_ADD, 1, (65535 + 1) % 65536);
        report_test("add", errors_before);
    endtask

    task automatic test_sub();
        int errors_before;
        int a;
        int b;
        errors_before = error_count;
        calculate(25, OP_SUB, 300, (25 + 65536 - 300) % 65536);
        repeat (10) begin
            a = $urandom % 65536;
            b = $urandom % 65536;
            calculate(a, OP_SUB, b, (a + 65536 - b) % 65536);
        end
        report_test("subtract", errors_before);
    endtask

    task automatic test_mul();
        int errors_before;
        int a;
        int b;
        errors_before = error_count;
        calculate(250, OP_MUL, 300, (250 * 300) % 65536);
        repeat (10) begin
            a = $urandom % 1000;         // Up to three digits
            b = $urandom % 1000;
            calculate(a, OP_MUL, b, (a * b) % 65536);
        end
        report_test("multiply", errors_before);
    endtask

    task automatic test_ignored();
        int errors_before;
        int cycles;
        errors_before = error_count;
        press_digit(4'd1);
        press_digit(4'd2);
        press_digit(4'd12);              // Not a decimal digit
        press_operator(3'b011);          // Not one-hot
        press_digit(4'd3);
        press_operator(OP_ADD);
        press_digit(4'd4);
        press_digit(4'd12);
        press_digit(4'd5);
        press_equal();
        wait_complete(cycles);
        check_value("display_output", display_output, operand_t'(123 + 45));
        check_value("latency", operand_t'(cycles), operand_t'(3));
        enter_number(12);
        press_operator(OP_MUL);
        enter_number(34);
        press_equal();
        press_digit(4'd7);               // Multiplier still busy
        wait_complete(cycles);
        check_value("display_output", display_output, operand_t'(12 * 34));
        // Digit press used two of the cycles
        check_value("latency", operand_t'(cycles + 2), operand_t'(OPERAND_W + 2));
        calculate(5, OP_ADD, 6, 11);
        report_test("ignored inputs", errors_before);
    endtask

    task automatic test_overflow();
        int errors_before;
        errors_before = error_count;
        calculate(99999, OP_ADD, 0, 99999 % 65536);
        calculate(7, OP_ADD, 8, 15);     // Starts from cleared operands
        apply_reset();
        @(negedge clk);
        check_value("display_output", display_output, '0);
        check_value("complete", operand_t'(complete), '0);
        report_test("overflow and clear", errors_before);
    endtask

    initial begin
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        error_count    = 0;
        check_count    = 0;
        test_count     = 0;
        void'($urandom(32'h0cdb_32e6));
        apply_reset();
        test_reset();
        test_add();
        test_sub();
        test_mul();
        test_ignored();
        test_overflow();
        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb/calculator_sva.sv
`timescale 1ns/10ps

module calculator_sva #(
    parameter bit CHECK_DISPLAY = 1'b1   // Display checks need complete
) (
    input logic clk,
    input logic nRST,
    input logic start_add,
    input logic start_mult,
    input logic add_finish,
    input logic mult_finish,
    input logic complete
);
    a_start_exclusive: assert property (@(posedge clk) disable iff (!nRST)
        !(start_add && start_mult)) else $error("start_add and start_mult high together");

    a_add_pulse: assert property (@(posedge clk) disable iff (!nRST)
        start_add |=> !start_add) else $error("start_add longer than one cycle");

    a_mult_pulse: assert property (@(posedge clk) disable iff (!nRST)
        start_mult |=> !start_mult) else $error("start_mult longer than one cycle");

    if (CHECK_DISPLAY) begin : g_display
        a_complete_set: assert property (@(posedge clk) disable iff (!nRST)
            (add_finish || mult_finish) |=> complete) else $error("complete missing after finish");

        a_complete_rise: assert property (@(posedge clk) disable iff (!nRST)
            $rose(complete) |-> $past(add_finish || mult_finish))
            else $error("complete rose without a finish pulse");
    end

endmodule

bind calc_entry calculator_sva #(.CHECK_DISPLAY(1'b0)) i_entry_sva (
    .clk         (clk),
    .nRST        (nRST),
    .start_add   (start_add),
    .start_mult  (start_mult),
    .add_finish  (add_finish),
    .mult_finish (mult_finish),
    .complete    (1'b0)
);

bind result_display calculator_sva i_display_sva (
    .clk         (clk),
    .nRST        (nRST),
    .start_add   (start_add),
    .start_mult  (start_mult),
    .add_finish  (add_finish),
    .mult_finish (mult_finish),
    .complete    (complete)
);

//--- hdl/calculator_top.sv
`timescale 1ns/10ps

module calculator_top (
    input  logic               clk,
    input  logic               nRST,
    input  calc_pkg::digit_t   keypad_input,
    input  logic               read_input,
    input  calc_pkg::op_code_t operator_input,
    input  logic               equal_input,
    output calc_pkg::operand_t display_output,
    output logic               complete
);
    import calc_pkg::*;

    operand_t operand_a;
    operand_t operand_b;
    operand_t add_result;
    operand_t mult_result;
    logic     subtract;
    logic     start_add;
    logic     start_mult;
    logic     add_finish;
    logic     mult_finish;

    calc_entry i_calc_entry (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .add_finish     (add_finish),
        .mult_finish    (mult_finish),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .subtract       (subtract),
        .start_add      (start_add),
        .start_mult     (start_mult)
    );

    add_sub_unit #(
        .WIDTH (OPERAND_W)
    ) i_add_sub_unit (
        .clk      (clk),
        .nRST     (nRST),
        .in_a     (operand_a),
        .in_b     (operand_b),
        .subtract (subtract),
        .start    (start_add),
        .result   (add_result),
        .finish   (add_finish)
    );

    shift_add_multiplier #(
        .WIDTH (OPERAND_W)
    ) i_shift_add_multiplier (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_mult),
        .in_a   (operand_a),
        .in_b   (operand_b),
        .result (mult_result),
        .finish (mult_finish)
    );

    result_display i_result_display (
        .clk            (clk),
        .nRST           (nRST),
        .add_result     (add_result),
        .mult_result    (mult_result),
        .add_finish     (add_finish),
        .mult_finish    (mult_finish),
        .start_add      (start_add),
        .start_mult     (start_mult),
        .display_output (display_output),
        .complete       (complete)
    );

endmodule

//--- hdl/result_display.sv
`timescale 1ns/10ps

module result_display (
    input  logic               clk,
    input  logic               nRST,
    input  calc_pkg::operand_t add_result,
    input  calc_pkg::operand_t mult_result,
    input  logic               add_finish,
    input  logic               mult_finish,
    input  logic               start_add,
    input  logic               start_mult,
    output calc_pkg::operand_t display_output,
    output logic               complete
);
    logic any_finish;
    logic any_start;

    assign any_finish = add_finish || mult_finish;
    assign any_start  = start_add || start_mult;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_output <= '0;
            complete       <= 1'b0;
        end else begin
            // Only one unit runs at a time
            if (add_finish) begin
                display_output <= add_result;
            end else if (mult_finish) begin
                display_output <= mult_result;
            end

            if (any_finish) begin
                complete <= 1'b1;        // Set together with the load
            end else if (any_start) begin
                complete <= 1'b0;        // New calculation under way
            end
        end
    end

endmodule

//--- hdl/shift_add_multiplier.sv
`timescale 1ns/10ps

module shift_add_multiplier #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    output logic [WIDTH-1:0] result,
    output logic             finish
);
    localparam int CNT_W = $clog2(WIDTH);

    logic [WIDTH-1:0] acc;          // Low half of the running product
    logic [WIDTH-1:0] mcand;        // Multiplicand, shifted left per step
    logic [WIDTH-1:0] mplier;       // Multiplier, shifted right per step
    logic [CNT_W-1:0] steps_left;
    logic             running;

    // Bit 0 is handled at load, bits 1..WIDTH-1 one per cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running    <= 1'b0;
            steps_left <= '0;
            finish     <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running    <= 1'b1;
                steps_left <= CNT_W'(WIDTH - 1);
            end else if (running) begin
                steps_left <= steps_left - 1'b1;
                if (steps_left == CNT_W'(1)) begin
                    running <= 1'b0;
                    finish  <= 1'b1;     // Last partial product added
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= in_b[0] ? in_a : '0;
            mcand  <= in_a << 1;
            mplier <= in_b >> 1;
        end else if (running) begin
            if (mplier[0]) begin
                acc <= acc + mcand;      // Upper product bits fall off
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign result = acc;

endmodule

//--- hdl/add_sub_unit.sv
`timescale 1ns/10ps

module add_sub_unit #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    input  logic             subtract,
    input  logic             start,
    output logic [WIDTH-1:0] result,
    output logic             finish
);
    logic [WIDTH-1:0] b_term;    // B or its ones' complement
    logic [WIDTH-1:0] carry_in;

    // Two's complement subtract as a + ~b + 1
    assign b_term   = subtract ? ~in_b : in_b;
    assign carry_in = {{(WIDTH-1){1'b0}}, subtract};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;         // One-cycle pulse after start
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= in_a + b_term + carry_in;   // Wraps modulo 2^WIDTH
        end
    end

endmodule

//--- hdl/calc_entry.sv
`timescale 1ns/10ps

module calc_entry (
    input  logic               clk,
    input  logic               nRST,
    input  calc_pkg::digit_t   keypad_input,
    input  logic               read_input,
    input  calc_pkg::op_code_t operator_input,
    input  logic               equal_input,
    input  logic               add_finish,
    input  logic               mult_finish,
    output calc_pkg::operand_t operand_a,
    output calc_pkg::operand_t operand_b,
    output logic               subtract,
    output logic               start_add,
    output logic               start_mult
);
    import calc_pkg::*;

    typedef enum logic [1:0] {
        GET_FIRST,
        GET_SECOND,
        LAUNCH,
        BUSY
    } state_t;

    state_t state;
    state_t next_state;

    logic mult_sel;       // Latched operator selects the multiplier
    logic op_valid;       // Exactly one legal operator code
    logic digit_valid;    // Read strobe with a decimal digit
    logic take_digit;     // Digit folded into an operand this cycle
    logic unit_finish;

    // Decimal append, x*10 done as x*8 + x*2
    function automatic operand_t append_digit(operand_t value, digit_t digit);
        operand_t times_ten;
        times_ten = (value << 3) + (value << 1);
        return times_ten + operand_t'(digit);
    endfunction

    assign op_valid    = operator_input inside {OP_ADD, OP_SUB, OP_MUL};
    assign digit_valid = read_input && (keypad_input <= MAX_DIGIT);
    assign unit_finish = add_finish || mult_finish;

    // Operator or equal in the same cycle wins over a digit
    always_comb begin
        case (state)
            GET_FIRST:  take_digit = digit_valid && !op_valid;
            GET_SECOND: take_digit = digit_valid && !equal_input;
            default:    take_digit = 1'b0;   // Dropped while busy
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            GET_FIRST: begin
                if (op_valid) begin
                    next_state = GET_SECOND;
                end
            end
            GET_SECOND: begin
                if (equal_input) begin
                    next_state = LAUNCH;
                end
            end
            LAUNCH: begin
                next_state = BUSY;           // Single start cycle
            end
            BUSY: begin
                if (unit_finish) begin
                    next_state = GET_FIRST;
                end
            end
            default: begin
                next_state = GET_FIRST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= GET_FIRST;
            operand_a <= '0;
            operand_b <= '0;
            subtract  <= 1'b0;
            mult_sel  <= 1'b0;
        end else begin
            state <= next_state;

            if (state == GET_FIRST && op_valid) begin
                subtract <= (operator_input == OP_SUB);
                mult_sel <= (operator_input == OP_MUL);
            end

            if (take_digit && state == GET_FIRST) begin
                operand_a <= append_digit(operand_a, keypad_input);
            end
            if (take_digit && state == GET_SECOND) begin
                operand_b <= append_digit(operand_b, keypad_input);
            end

            // Operands held through the calculation, then cleared
            if (state == BUSY && unit_finish) begin
                operand_a <= '0;
                operand_b <= '0;
            end
        end
    end

    assign start_add  = (state == LAUNCH) && !mult_sel;
    assign start_mult = (state == LAUNCH) && mult_sel;

endmodule

//--- hdl/calc_pkg.sv
package calc_pkg;

    // Datapath width for operands, unit results and the display
    localparam int OPERAND_W = 16;

    typedef logic [OPERAND_W-1:0] operand_t;   // Unsigned, wraps modulo 2^16
    typedef logic [3:0]           digit_t;     // One keypad code
    typedef logic [2:0]           op_code_t;   // One-hot operator

    // One-hot operator encodings
    localparam op_code_t OP_ADD = 3'b001;
    localparam op_code_t OP_SUB = 3'b010;
    localparam op_code_t OP_MUL = 3'b100;

    // Codes above this are not decimal digits
    localparam digit_t MAX_DIGIT = 4'd9;

endpackage
